// File: common/qe_cfg.svh
//////////////////////////////////////////////////
// quadrature encoder channel configuration
// word and address widths, synchronizer depth,
// register word offsets
//////////////////////////////////////////////////

`ifndef QE_CFG_SVH
`define QE_CFG_SVH

// register word and address widths
`define QE_DATA_W              32
`define QE_ADDR_W              3

// flop stages on each external encoder pin
`define QE_SYNC_STAGES         2

// register word offsets
`define QE_REG_COUNT           0
`define QE_REG_TURNS           1
`define QE_REG_PHASE_TIME      2
`define QE_REG_COUNTS_PER_REV  3
`define QE_REG_CONFIG          4
`define QE_REG_STATUS          5

`endif

// File: common/qe_reg_pkg.sv
//////////////////////////////////////////////////
// register map types for the encoder channel
// address enum, config word union, status word
//////////////////////////////////////////////////

`include "qe_cfg.svh"

package qe_reg_pkg;

    // register address as seen on the request port
    typedef logic [`QE_ADDR_W-1:0] qe_addr_t;

    // named offsets, values 6 and 7 are unused
    typedef enum qe_addr_t {
        qe_addr_count          = `QE_REG_COUNT,
        qe_addr_turns          = `QE_REG_TURNS,
        qe_addr_phase_time     = `QE_REG_PHASE_TIME,
        qe_addr_counts_per_rev = `QE_REG_COUNTS_PER_REV,
        qe_addr_config         = `QE_REG_CONFIG,
        qe_addr_status         = `QE_REG_STATUS
    } qe_reg_e;

    // config fields, bit 0 at the bottom
    typedef struct packed {
        logic [`QE_DATA_W-5:0] reserved;
        logic                  flip_ab;
        // 0 clockwise, 1 counter-clockwise
        logic                  sim_direction;
        logic                  sim_enable;
        // 0 external pins, 1 internal generator
        logic                  source;
    } qe_config_s;

    // bus side sees raw, datapath sees fields
    typedef union packed {
        logic [`QE_DATA_W-1:0] raw;
        qe_config_s            f;
    } qe_config_u;

    // pin levels, synchronized pins in the low three bits
    typedef struct packed {
        logic sel_i;
        logic sel_b;
        logic sel_a;
        logic ext_i;
        logic ext_b;
        logic ext_a;
    } qe_status_t;

endpackage

// File: common/qe_signal_pkg.sv
//////////////////////////////////////////////////
// encoder signal types
// source select, direction, quadrature phase
//////////////////////////////////////////////////

package qe_signal_pkg;

    // where the decoder takes A, B and I from
    typedef enum logic {
        qe_external = 1'b0,
        qe_internal = 1'b1
    } qe_source_e;

    // rotation sense
    // clockwise walks A/B through 00, 10, 11, 01
    typedef enum logic {
        qe_cw  = 1'b0,
        qe_ccw = 1'b1
    } qe_dir_e;

    // position inside one quadrature cycle
    // also used as the decoder's gray index
    typedef logic [1:0] qe_phase_t;

    // 0 .. 3 index of an A/B level pair along the cw sequence
    function automatic qe_phase_t ab_to_phase(input logic a, input logic b);
        return {b, a ^ b};
    endfunction

endpackage

// File: hw/qe_reg_bank.sv
//////////////////////////////////////////////////
// register bank of the encoder channel
// valid/ready request and response handshake,
// writable registers, readback mux, count preload
//////////////////////////////////////////////////

`include "qe_cfg.svh"

module qe_reg_bank import qe_reg_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // request side
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  qe_addr_t              req_addr,
    input  logic [`QE_DATA_W-1:0] req_wdata,
    // response side
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [`QE_DATA_W-1:0] resp_rdata,
    // towards the datapath
    output qe_config_u            cfg,
    output logic [`QE_DATA_W-1:0] phase_time,
    output logic [`QE_DATA_W-1:0] counts_per_rev,
    output logic                  count_load,
    output logic [`QE_DATA_W-1:0] count_load_value,
    // from the datapath
    input  logic [`QE_DATA_W-1:0] count,
    input  logic [`QE_DATA_W-1:0] turns,
    input  qe_status_t            status
);

    logic                  accept;
    logic                  wr_en;
    logic [`QE_DATA_W-1:0] rd_word;

    //////////////////////////////////////////////////
    // handshake

    // one request in flight, a waiting response blocks new ones
    assign req_ready = !resp_valid;
    assign accept    = req_valid && req_ready;
    assign wr_en     = accept && req_write;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_valid && resp_ready) begin
            // response taken
            resp_valid <= 1'b0;
        end
    end

    // response word captured once, held through any stall
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_rdata <= req_write ? '0 : rd_word;
        end
    end

    //////////////////////////////////////////////////
    // writable registers

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cfg.raw        <= '0;
            phase_time     <= '0;
            counts_per_rev <= '0;
        end else if (wr_en) begin
            case (req_addr)
                qe_addr_phase_time:     phase_time     <= req_wdata;
                qe_addr_counts_per_rev: counts_per_rev <= req_wdata;
                // reserved bits kept as written
                qe_addr_config:         cfg.raw        <= req_wdata;
                default: ;
            endcase
        end
    end

    // count itself lives in the decoder, a write there is a preload
    assign count_load       = wr_en && (req_addr == qe_addr_count);
    assign count_load_value = req_wdata;

    //////////////////////////////////////////////////
    // readback

    always_comb begin
        rd_word = '0;
        case (req_addr)
            qe_addr_count:          rd_word = count;
            qe_addr_turns:          rd_word = turns;
            qe_addr_phase_time:     rd_word = phase_time;
            qe_addr_counts_per_rev: rd_word = counts_per_rev;
            qe_addr_config:         rd_word = cfg.raw;
            // status zero-extended
            qe_addr_status:
                rd_word = {{(`QE_DATA_W - $bits(qe_status_t)){1'b0}}, status};
            // offsets 6 and 7 read zero
            default:                rd_word = '0;
        endcase
    end

endmodule

// File: encoder_sim/qe_pattern_gen.sv
//////////////////////////////////////////////////
// simulated quadrature encoder
// phase timer, phase and pulse counters, A/B/I
//////////////////////////////////////////////////

`include "qe_cfg.svh"

module qe_pattern_gen import qe_reg_pkg::*, qe_signal_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  qe_config_u            cfg,
    input  logic [`QE_DATA_W-1:0] phase_time,
    input  logic [`QE_DATA_W-1:0] counts_per_rev,
    output logic                  sim_a,
    output logic                  sim_b,
    output logic                  sim_i
);

    logic [`QE_DATA_W-1:0] phase_timer;
    logic [`QE_DATA_W-1:0] pulse_cnt;
    qe_phase_t             phase;
    logic                  expire;
    logic                  cw_a;
    logic                  cw_b;

    // timer at zero ends the current phase
    assign expire = cfg.f.sim_enable && (phase_timer == '0);

    //////////////////////////////////////////////////
    // phase timer and counters

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase_timer <= '0;
            pulse_cnt   <= '0;
            phase       <= '0;
            sim_i       <= 1'b0;
        end else if (!cfg.f.sim_enable) begin
            // idle, keep phase and I, timer primed for a full first phase
            phase_timer <= phase_time;
        end else if (expire) begin
            phase_timer <= phase_time;
            phase       <= phase + 2'd1;
            if (pulse_cnt == counts_per_rev) begin
                // one revolution done, index for the next phase
                pulse_cnt <= '0;
                sim_i     <= 1'b1;
            end else begin
                pulse_cnt <= pulse_cnt + 1'b1;
                sim_i     <= 1'b0;
            end
        end else begin
            phase_timer <= phase_timer - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // A/B levels

    // clockwise order 00, 10, 11, 01 as gray code of the phase
    assign cw_a = phase[0] ^ phase[1];
    assign cw_b = phase[1];

    // counter-clockwise order 00, 01, 11, 10 is the same walk with A and B swapped
    always_comb begin
        if (qe_dir_e'(cfg.f.sim_direction) == qe_ccw) begin
            sim_a = cw_b;
            sim_b = cw_a;
        end else begin
            sim_a = cw_a;
            sim_b = cw_b;
        end
    end

endmodule

// File: hw/qe_input_select.sv
//////////////////////////////////////////////////
// encoder input selection
// pin synchronizers, source mux, A/B swap, status
//////////////////////////////////////////////////

`include "qe_cfg.svh"

module qe_input_select import qe_reg_pkg::*, qe_signal_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // asynchronous encoder pins
    input  logic       enc_a,
    input  logic       enc_b,
    input  logic       enc_i,
    // internal generator
    input  logic       sim_a,
    input  logic       sim_b,
    input  logic       sim_i,
    input  qe_config_u cfg,
    output logic       sel_a,
    output logic       sel_b,
    output logic       sel_i,
    output qe_status_t status
);

    // one flop chain per pin, bit order {i, b, a}
    logic [`QE_SYNC_STAGES-1:0][2:0] sync_q;
    logic [2:0]                      ext;
    logic [2:0]                      src;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= {enc_i, enc_b, enc_a};
            for (int k = 1; k < `QE_SYNC_STAGES; k++) begin
                sync_q[k] <= sync_q[k-1];
            end
        end
    end

    assign ext = sync_q[`QE_SYNC_STAGES-1];

    // generator path has no flops
    assign src = (qe_source_e'(cfg.f.source) == qe_internal) ? {sim_i, sim_b, sim_a} : ext;

    // swap corrects a reversed A/B wiring
    assign sel_a = cfg.f.flip_ab ? src[1] : src[0];
    assign sel_b = cfg.f.flip_ab ? src[0] : src[1];
    assign sel_i = src[2];

    assign status = '{sel_i: sel_i, sel_b: sel_b, sel_a: sel_a,
                      ext_i: ext[2], ext_b: ext[1], ext_a: ext[0]};

endmodule

// File: decoder/qe_decoder.sv
//////////////////////////////////////////////////
// x4 quadrature decoder
// transition decode, position and turns counters
//////////////////////////////////////////////////

`include "qe_cfg.svh"

module qe_decoder import qe_signal_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sel_a,
    input  logic                  sel_b,
    input  logic                  sel_i,
    // preload from the register bank
    input  logic                  count_load,
    input  logic [`QE_DATA_W-1:0] count_load_value,
    // two's complement counters
    output logic [`QE_DATA_W-1:0] count,
    output logic [`QE_DATA_W-1:0] turns
);

    logic      prev_a;
    logic      prev_b;
    logic      prev_i;
    qe_dir_e   last_dir;
    qe_dir_e   turn_dir;
    qe_phase_t delta;
    logic      step_fwd;
    logic      step_rev;
    logic      i_rise;

    //////////////////////////////////////////////////
    // transition decode

    // distance along 00, 10, 11, 01 from last sample to this one
    assign delta    = ab_to_phase(sel_a, sel_b) - ab_to_phase(prev_a, prev_b);
    assign step_fwd = (delta == 2'd1);
    // 3 is one step back, 2 is a skipped level and is dropped
    assign step_rev = (delta == 2'd3);
    assign i_rise   = sel_i && !prev_i;

    // an index edge together with a step takes that step's sense
    always_comb begin
        if (step_fwd) begin
            turn_dir = qe_cw;
        end else if (step_rev) begin
            turn_dir = qe_ccw;
        end else begin
            turn_dir = last_dir;
        end
    end

    //////////////////////////////////////////////////
    // counters

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prev_a   <= 1'b0;
            prev_b   <= 1'b0;
            prev_i   <= 1'b0;
            last_dir <= qe_cw;
            count    <= '0;
            turns    <= '0;
        end else begin
            prev_a   <= sel_a;
            prev_b   <= sel_b;
            prev_i   <= sel_i;
            last_dir <= turn_dir;

            // preload wins over a step in the same cycle
            if (count_load) begin
                count <= count_load_value;
            end else if (step_fwd) begin
                count <= count + 1'b1;
            end else if (step_rev) begin
                count <= count - 1'b1;
            end

            if (i_rise) begin
                turns <= (turn_dir == qe_cw) ? turns + 1'b1 : turns - 1'b1;
            end
        end
    end

endmodule

// File: hw/qe_channel.sv
//////////////////////////////////////////////////
// quadrature encoder channel top level
// register bank, generator, input select, decoder
//////////////////////////////////////////////////

`include "qe_cfg.svh"

module qe_channel import qe_reg_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  qe_addr_t              req_addr,
    input  logic [`QE_DATA_W-1:0] req_wdata,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [`QE_DATA_W-1:0] resp_rdata,
    input  logic                  enc_a,
    input  logic                  enc_b,
    input  logic                  enc_i
);

    // register bank outputs
    qe_config_u            cfg;
    logic [`QE_DATA_W-1:0] phase_time;
    logic [`QE_DATA_W-1:0] counts_per_rev;
    logic                  count_load;
    logic [`QE_DATA_W-1:0] count_load_value;
    // datapath
    logic                  sim_a, sim_b, sim_i;
    logic                  sel_a, sel_b, sel_i;
    qe_status_t            status;
    logic [`QE_DATA_W-1:0] count;
    logic [`QE_DATA_W-1:0] turns;

    qe_reg_bank i_qe_reg_bank (
        .clk, .reset,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .resp_valid, .resp_ready, .resp_rdata,
        .cfg, .phase_time, .counts_per_rev, .count_load, .count_load_value,
        .count, .turns, .status
    );

    qe_pattern_gen i_qe_pattern_gen (
        .clk, .reset,
        .cfg, .phase_time, .counts_per_rev,
        .sim_a, .sim_b, .sim_i
    );

    qe_input_select i_qe_input_select (
        .clk, .reset,
        .enc_a, .enc_b, .enc_i,
        .sim_a, .sim_b, .sim_i,
        .cfg,
        .sel_a, .sel_b, .sel_i,
        .status
    );

    qe_decoder i_qe_decoder (
        .clk, .reset,
        .sel_a, .sel_b, .sel_i,
        .count_load, .count_load_value,
        .count, .turns
    );

endmodule

// File: testbench/qe_channel_sva.sv
//////////////////////////////////////////////////
// handshake assertions for the register port
// bound into the channel top level
//////////////////////////////////////////////////

`include "qe_cfg.svh"

module qe_channel_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  req_valid,
    input logic                  req_ready,
    input logic                  resp_valid,
    input logic                  resp_ready,
    input logic [`QE_DATA_W-1:0] resp_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    // a taken response leaves the port idle on the next edge
    resp_clear: assert property (@(posedge clk) disable iff (!reset)
        resp_valid && resp_ready |=> !resp_valid)
        else $error("response still pending after it was taken");

    // response word frozen until it is taken
    stall_hold: assert property (@(posedge clk) disable iff (!reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else $error("stalled response changed or dropped");

    // one edge from acceptance to response
    resp_next: assert property (@(posedge clk) disable iff (!reset)
        req_valid && req_ready |=> resp_valid)
        else $error("no response one cycle after acceptance");

endmodule

bind qe_channel qe_channel_sva i_qe_channel_sva (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata)
);

// File: testbench/qe_channel_tb.sv
//////////////////////////////////////////////////
// testbench for the encoder channel
// register table, encoder pin driver,
// generator runs, response stalls
//////////////////////////////////////////////////

module qe_channel_tb import qe_reg_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          WAIT_LIMIT = 50;
    localparam int          POLL_LIMIT = 100;
    // cycles each pin level is held, well above sync plus decode
    localparam int          HOLD       = 5;
    localparam int          PHASE_TIME = 2;
    localparam int          CPR        = 7;
    localparam logic [31:0] SEED       = 32'h52a8_9aee;

    // one register step: direction, offset, write data, expected response
    typedef struct packed {
        logic        write;
        qe_addr_t    addr;
        logic [31:0] data;
        logic [31:0] exp_data;
    } reg_step_t;

    localparam int N_STEPS = 20;
    localparam reg_step_t REG_TABLE [N_STEPS] = '{
        // everything reads zero out of reset, unused offsets too
        '{1'b0, qe_addr_count,          32'h0,         32'h0},
        '{1'b0, qe_addr_turns,          32'h0,         32'h0},
        '{1'b0, qe_addr_phase_time,     32'h0,         32'h0},
        '{1'b0, qe_addr_counts_per_rev, 32'h0,         32'h0},
        '{1'b0, qe_addr_config,         32'h0,         32'h0},
        '{1'b0, qe_addr_status,         32'h0,         32'h0},
        '{1'b0, 3'd6,                   32'h0,         32'h0},
        '{1'b0, 3'd7,                   32'h0,         32'h0},
        // writable registers read back as written
        '{1'b1, qe_addr_phase_time,     32'h1234_5678, 32'h0},
        '{1'b0, qe_addr_phase_time,     32'h0,         32'h1234_5678},
        '{1'b1, qe_addr_counts_per_rev, 32'h0000_00ff, 32'h0},
        '{1'b0, qe_addr_counts_per_rev, 32'h0,         32'h0000_00ff},
        // reserved config bits kept, low control bits left clear
        '{1'b1, qe_addr_config,         32'hf00d_bee0, 32'h0},
        '{1'b0, qe_addr_config,         32'h0,         32'hf00d_bee0},
        // read-only registers ignore writes
        '{1'b1, qe_addr_turns,          32'hdead_beef, 32'h0},
        '{1'b0, qe_addr_turns,          32'h0,         32'h0},
        '{1'b1, qe_addr_status,         32'hffff_ffff, 32'h0},
        '{1'b0, qe_addr_status,         32'h0,         32'h0},
        '{1'b1, qe_addr_config,         32'h0,         32'h0},
        '{1'b0, qe_addr_config,         32'h0,         32'h0}
    };

    // clockwise A/B levels {a, b}
    localparam logic [1:0] CW_AB [4] = '{2'b00, 2'b10, 2'b11, 2'b01};

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    qe_addr_t    req_addr;
    logic [31:0] req_wdata;
    logic        resp_valid;
    logic        resp_ready;
    logic [31:0] resp_rdata;
    logic        enc_a;
    logic        enc_b;
    logic        enc_i;
    logic [31:0] rng;
    logic [1:0]  pin_pos;

    qe_channel i_qe_channel (
        .clk, .reset,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .resp_valid, .resp_ready, .resp_rdata,
        .enc_a, .enc_b, .enc_i
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display("Test FAILED");
        $fatal(1, "wait limit exceeded");
    endtask

    //////////////////////////////////////////////////
    // register access

    // entered and left on a falling edge
    task automatic bus_access(input logic write, input qe_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        int stall;
        rng = xorshift(rng);
        stall = int'(rng % 4);
        waited = 0;
        while (!req_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                timeout_fail("req_ready stayed low");
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        @(negedge clk);
        req_valid = 1'b0;
        waited = 0;
        while (!resp_valid) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                timeout_fail("no response after an accepted request");
        end
        rdata = resp_rdata;
        // held response blocks new requests
        repeat (stall) begin
            @(negedge clk);
            check("resp_valid", 32'(resp_valid), 32'd1);
            check("req_ready", 32'(req_ready), 32'd0);
            check("resp_rdata", resp_rdata, rdata);
        end
        resp_ready = 1'b1;
        @(negedge clk);
        resp_ready = 1'b0;
        check("resp_valid", 32'(resp_valid), 32'd0);
    endtask

    task automatic reg_write(input qe_addr_t addr, input logic [31:0] data);
        logic [31:0] rdata;
        bus_access(1'b1, addr, data, rdata);
        check("resp_rdata", rdata, 32'd0);
    endtask

    task automatic reg_read(input qe_addr_t addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'd0, data);
    endtask

    //////////////////////////////////////////////////
    // encoder pins

    task automatic pin_steps(input int n, input logic ccw);
        for (int k = 0; k < n; k++) begin
            pin_pos = ccw ? pin_pos - 2'd1 : pin_pos + 2'd1;
            {enc_a, enc_b} = CW_AB[pin_pos];
            repeat (HOLD) @(negedge clk);
        end
    endtask

    task automatic index_pulse();
        enc_i = 1'b1;
        repeat (HOLD) @(negedge clk);
        enc_i = 1'b0;
        repeat (HOLD) @(negedge clk);
    endtask

    // generator run in one direction, then frozen
    task automatic run_sim(input logic ccw);
        logic [31:0] rdata;
        logic [31:0] turns0;
        logic [31:0] dturns;
        int          polls;
        int          mag;
        // generator selected but idle while count is cleared
        reg_write(qe_addr_config, ccw ? 32'h5 : 32'h1);
        reg_write(qe_addr_count, 32'd0);
        reg_read(qe_addr_turns, turns0);
        reg_write(qe_addr_config, ccw ? 32'h7 : 32'h3);
        polls = 0;
        mag = 0;
        while (mag <= 2 * (CPR + 1)) begin
            reg_read(qe_addr_count, rdata);
            mag = rdata[31] ? -$signed(rdata) : $signed(rdata);
            polls++;
            if (polls > POLL_LIMIT)
                timeout_fail("generator count never reached its target");
        end
        check("count sign", 32'(rdata[31]), 32'(ccw));
        reg_read(qe_addr_turns, rdata);
        dturns = rdata - turns0;
        check("turns change", 32'(dturns != 0), 32'd1);
        check("turns sign", 32'(dturns[31]), 32'(ccw));
        // disabled generator keeps its phase
        reg_write(qe_addr_config, ccw ? 32'h5 : 32'h1);
        reg_read(qe_addr_count, turns0);
        repeat (20) @(negedge clk);
        reg_read(qe_addr_count, rdata);
        check("frozen count", rdata, turns0);
    endtask

    initial begin
        logic [31:0] rdata;
        int          ncw;
        int          nccw;
        int          diff;
        clk        = 1'b0;
        reset      = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        resp_ready = 1'b0;
        enc_a      = 1'b0;
        enc_b      = 1'b0;
        enc_i      = 1'b0;
        rng        = SEED;
        pin_pos    = 2'd0;
        repeat (3) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        // register table
        for (int n = 0; n < N_STEPS; n++) begin
            reg_step_t st;
            st = REG_TABLE[n];
            bus_access(st.write, st.addr, st.data, rdata);
            check("resp_rdata", rdata, st.exp_data);
        end

        // external pins, straight then swapped
        rng = xorshift(rng);
        ncw = 1 + int'(rng % 16);
        rng = xorshift(rng);
        nccw = 1 + int'(rng % 16);
        diff = ncw - nccw;
        for (int flip = 0; flip < 2; flip++) begin
            reg_write(qe_addr_config, (flip != 0) ? 32'h8 : 32'h0);
            reg_write(qe_addr_count, 32'd0);
            pin_steps(ncw, 1'b0);
            pin_steps(nccw, 1'b1);
            reg_read(qe_addr_count, rdata);
            check("count", rdata, (flip != 0) ? -diff : diff);
            reg_read(qe_addr_status, rdata);
            if (flip != 0)
                check("status", rdata, {26'b0, enc_i, enc_a, enc_b, enc_i, enc_b, enc_a});
            else
                check("status", rdata, {26'b0, enc_i, enc_b, enc_a, enc_i, enc_b, enc_a});
        end

        // preload and index edges
        reg_write(qe_addr_config, 32'h0);
        reg_write(qe_addr_count, 32'h100);
        reg_read(qe_addr_count, rdata);
        check("count", rdata, 32'h100);
        pin_steps(3, 1'b0);
        reg_read(qe_addr_count, rdata);
        check("count", rdata, 32'h103);
        index_pulse();
        index_pulse();
        reg_read(qe_addr_turns, rdata);
        check("turns", rdata, 32'd2);
        pin_steps(2, 1'b1);
        reg_read(qe_addr_count, rdata);
        check("count", rdata, 32'h101);
        index_pulse();
        index_pulse();
        reg_read(qe_addr_turns, rdata);
        check("turns", rdata, 32'd0);

        // internal generator
        reg_write(qe_addr_phase_time, PHASE_TIME);
        reg_write(qe_addr_counts_per_rev, CPR);
        run_sim(1'b0);
        run_sim(1'b1);

        $display("Test OK");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/qe_reg_pkg.sv
common/qe_signal_pkg.sv
hw/qe_reg_bank.sv
encoder_sim/qe_pattern_gen.sv
hw/qe_input_select.sv
decoder/qe_decoder.sv
hw/qe_channel.sv
testbench/qe_channel_sva.sv
testbench/qe_channel_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := qe_channel_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/qe_cfg.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@if grep -q "Test FAILED" $(SIM_LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(SIM_LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
